//--- src/pingpong_pkg.sv
`default_nettype none

package pingpong_pkg;

    typedef logic [3:0] count_t;
    typedef logic [7:0] seg_t;      // Active low, bits 0..6 are a..g, bit 7 is dp
    typedef logic [3:0] anode_t;    // Active low, one per digit

    typedef struct packed {
        count_t value;
        logic   up;                 // 1 when counting up
    } counter_state_t;

    typedef struct packed {
        count_t min_value;
        count_t max_value;
    } bounds_t;

    // Direction glyphs
    localparam seg_t SEG_UP    = 8'b1101_1100;  // a, b, f
    localparam seg_t SEG_DOWN  = 8'b1110_0011;  // c, d, e
    localparam seg_t SEG_BLANK = 8'b1111_1111;

    // Numerals for 0..9, hex letters with dp lit for anything larger
    function automatic seg_t seg_of_digit(count_t digit);
        seg_t pattern;
        case (digit)
            4'd0:    pattern = 8'b1100_0000;
            4'd1:    pattern = 8'b1111_1001;
            4'd2:    pattern = 8'b1010_0100;
            4'd3:    pattern = 8'b1011_0000;
            4'd4:    pattern = 8'b1001_1001;
            4'd5:    pattern = 8'b1001_0010;
            4'd6:    pattern = 8'b1000_0010;
            4'd7:    pattern = 8'b1111_1000;
            4'd8:    pattern = 8'b1000_0000;
            4'd9:    pattern = 8'b1001_0000;
            4'ha:    pattern = 8'b0000_1000;
            4'hb:    pattern = 8'b0000_0011;
            4'hc:    pattern = 8'b0100_0110;
            4'hd:    pattern = 8'b0010_0001;
            4'he:    pattern = 8'b0000_0110;
            default: pattern = 8'b0000_1110;    // F
        endcase
        return pattern;
    endfunction

endpackage

`default_nettype wire

//--- src/tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tick_gen #(
    parameter int COUNT_DIV   = 50_000_000,
    parameter int REFRESH_DIV = 100_000
) (
    input  logic clk,
    input  logic rst_n,
    output logic count_tick,
    output logic refresh_tick
);

    localparam int CW = $clog2(COUNT_DIV);
    localparam int RW = $clog2(REFRESH_DIV);

    logic [CW-1:0] count_cnt;
    logic [RW-1:0] refresh_cnt;

    // Slow tick for the counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_cnt  <= '0;
            count_tick <= 1'b0;
        end else if (count_cnt == CW'(COUNT_DIV - 1)) begin
            count_cnt  <= '0;
            count_tick <= 1'b1;
        end else begin
            count_cnt  <= count_cnt + 1'b1;
            count_tick <= 1'b0;
        end
    end

    // Faster tick for button sampling and digit scan
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            refresh_cnt  <= '0;
            refresh_tick <= 1'b0;
        end else if (refresh_cnt == RW'(REFRESH_DIV - 1)) begin
            refresh_cnt  <= '0;
            refresh_tick <= 1'b1;
        end else begin
            refresh_cnt  <= refresh_cnt + 1'b1;
            refresh_tick <= 1'b0;
        end
    end

    a_div_min: assert property (@(posedge clk) COUNT_DIV >= 2 && REFRESH_DIV >= 2)
        else $error("tick_gen divisors must be at least 2");

endmodule

`default_nettype wire

//--- src/button_conditioner.sv
`timescale 1ns/1ns
`default_nettype none

module button_conditioner #(
    parameter int DEBOUNCE_LEN = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sample_tick,
    input  logic btn,
    output logic press_pulse
);

    logic [DEBOUNCE_LEN-1:0] samples;
    logic [DEBOUNCE_LEN-1:0] shifted;
    logic                    level;
    logic                    level_d;

    assign shifted = DEBOUNCE_LEN'({samples, btn});     // Newest sample enters at bit 0

    // Sample history with hysteresis on the debounced level
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            samples <= '0;
            level   <= 1'b0;
        end else if (sample_tick) begin
            samples <= shifted;
            if (&shifted) begin
                level <= 1'b1;
            end else if (~|shifted) begin
                level <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_d <= 1'b0;
        end else begin
            level_d <= level;
        end
    end

    assign press_pulse = level & ~level_d;  // Rising edge only

    // Pulse lands in the cycle right after a high sample
    a_pulse_after_sample: assert property (@(posedge clk) disable iff (!rst_n)
        press_pulse |-> $past(sample_tick) && $past(btn))
        else $error("press_pulse without a high button sample");

endmodule

`default_nettype wire

//--- src/ping_pong_counter.sv
`timescale 1ns/1ns
`default_nettype none

module ping_pong_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        count_tick,
    input  logic                        enable,
    input  logic                        flip_pulse,
    input  logic                        clear_pulse,
    input  pingpong_pkg::bounds_t       bounds,
    output pingpong_pkg::counter_state_t state
);

    import pingpong_pkg::*;

    logic           flip_pending;
    logic           flip_req;
    logic           step_ok;
    logic           next_up;
    counter_state_t stepped;

    // A flip arriving together with the tick is honoured right away
    assign flip_req = flip_pending | flip_pulse;
    assign step_ok  = enable && (bounds.max_value > bounds.min_value);

    // Turn at the bounds first, then step toward the chosen bound
    always_comb begin
        if (state.value == bounds.min_value) begin
            next_up = 1'b1;
        end else if (state.value == bounds.max_value) begin
            next_up = 1'b0;
        end else begin
            next_up = state.up;
        end

        stepped.up    = next_up;
        stepped.value = state.value;
        if (next_up && state.value < bounds.max_value) begin
            stepped.value = state.value + 1'b1;
        end else if (!next_up && state.value > bounds.min_value) begin
            stepped.value = state.value - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state.value  <= bounds.min_value;
            state.up     <= 1'b1;
            flip_pending <= 1'b0;
        end else if (clear_pulse) begin
            state.value  <= bounds.min_value;
            state.up     <= 1'b1;
            flip_pending <= 1'b0;   // Clear wins over a waiting flip
        end else if (count_tick) begin
            flip_pending <= 1'b0;
            if (flip_req) begin
                state.up <= ~state.up;  // Value holds on a flip step
            end else if (step_ok) begin
                state <= stepped;
            end
        end else if (flip_pulse) begin
            flip_pending <= 1'b1;
        end
    end

    // One step from inside the range never leaves it
    property p_stay_in_range;
        @(posedge clk) disable iff (!rst_n)
        (count_tick
         && state.value >= bounds.min_value
         && state.value <= bounds.max_value)
        ##1 $stable(bounds)
        |-> (state.value >= bounds.min_value && state.value <= bounds.max_value);
    endproperty

    a_stay_in_range: assert property (p_stay_in_range)
        else $error("counter value left the bounds");

endmodule

`default_nettype wire

//--- src/digit_scanner.sv
`timescale 1ns/1ns
`default_nettype none

module digit_scanner (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         refresh_tick,
    input  pingpong_pkg::counter_state_t state,
    output pingpong_pkg::anode_t         an,
    output pingpong_pkg::seg_t           seg
);

    import pingpong_pkg::*;

    logic [1:0] digit_idx;
    logic [1:0] next_idx;
    logic       started;    // Set by the first refresh tick
    count_t     ones;
    count_t     tens;
    seg_t       next_seg;

    assign next_idx = started ? digit_idx + 2'd1 : 2'd0;

    // Value is at most 15, so tens is 0 or 1
    always_comb begin
        if (state.value >= 4'd10) begin
            ones = state.value - 4'd10;
            tens = 4'd1;
        end else begin
            ones = state.value;
            tens = 4'd0;
        end
    end

    always_comb begin
        case (next_idx)
            2'd2:    next_seg = seg_of_digit(ones);
            2'd3:    next_seg = seg_of_digit(tens);
            default: next_seg = state.up ? SEG_UP : SEG_DOWN;   // Digits 0 and 1
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digit_idx <= 2'd0;
            started   <= 1'b0;
        end else if (refresh_tick) begin
            digit_idx <= next_idx;
            started   <= 1'b1;
        end
    end

    // Outputs registered so anode and segments switch together
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            an  <= '1;
            seg <= SEG_BLANK;
        end else if (refresh_tick) begin
            an  <= ~(anode_t'(1) << next_idx);
            seg <= next_seg;
        end
    end

    // Decimal split keeps every shown digit in 0..9, so dp stays dark
    a_decimal_digits: assert property (@(posedge clk) disable iff (!rst_n)
        seg[7])
        else $error("digit outside 0 to 9 on the display");

endmodule

`default_nettype wire

//--- src/pingpong_top.sv
`timescale 1ns/1ns
`default_nettype none

module pingpong_top #(
    parameter int COUNT_DIV    = 50_000_000,  // Half second at 100 MHz
    parameter int REFRESH_DIV  = 100_000,     // 1 ms per digit
    parameter int DEBOUNCE_LEN = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         enable,
    input  logic                         flip_btn,
    input  logic                         clear_btn,
    input  pingpong_pkg::bounds_t        bounds,
    output pingpong_pkg::seg_t           seg,
    output pingpong_pkg::anode_t         an,
    output pingpong_pkg::counter_state_t state
);

    logic count_tick;
    logic refresh_tick;
    logic flip_pulse;
    logic clear_pulse;

    tick_gen #(
        .COUNT_DIV   (COUNT_DIV),
        .REFRESH_DIV (REFRESH_DIV)
    ) u_tick_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .count_tick   (count_tick),
        .refresh_tick (refresh_tick)
    );

    button_conditioner #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) u_flip_cond (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_tick (refresh_tick),
        .btn         (flip_btn),
        .press_pulse (flip_pulse)
    );

    button_conditioner #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) u_clear_cond (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_tick (refresh_tick),
        .btn         (clear_btn),
        .press_pulse (clear_pulse)
    );

    ping_pong_counter u_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .count_tick  (count_tick),
        .enable      (enable),
        .flip_pulse  (flip_pulse),
        .clear_pulse (clear_pulse),
        .bounds      (bounds),
        .state       (state)
    );

    // Scanner reads the same state that leaves the top
    digit_scanner u_scanner (
        .clk          (clk),
        .rst_n        (rst_n),
        .refresh_tick (refresh_tick),
        .state        (state),
        .an           (an),
        .seg          (seg)
    );

endmodule

`default_nettype wire

//--- verif/tb_pingpong.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pingpong;

    import pingpong_pkg::*;

    localparam int COUNT_DIV      = 8;
    localparam int REFRESH_DIV    = 2;
    localparam int DEBOUNCE_LEN   = 3;
    localparam int TIMEOUT_CYCLES = 6000;   // About 50 count ticks of tests, wide margin

    logic           clk;
    logic           rst_n;
    logic           enable;
    logic           flip_btn;
    logic           clear_btn;
    bounds_t        bounds;
    seg_t           seg;
    anode_t         an;
    counter_state_t state;

    counter_state_t model;      // Expected counter state
    int             cyc;        // Edges since reset release, gives tick phase
    int             run_cycles;
    int             errors;
    int             checks;
    int             tests_run;
    int             tests_failed;
    integer         seed;

    pingpong_top #(
        .COUNT_DIV    (COUNT_DIV),
        .REFRESH_DIV  (REFRESH_DIV),
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .flip_btn  (flip_btn),
        .clear_btn (clear_btn),
        .bounds    (bounds),
        .seg       (seg),
        .an        (an),
        .state     (state)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= rst_n ? cyc + 1 : 0;
    end

    always @(posedge clk) begin
        run_cycles <= run_cycles + 1;
        if (run_cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // Counter rule: turn at a bound, then step if strictly inside
    function automatic counter_state_t model_step(counter_state_t s, bounds_t b, logic en);
        counter_state_t n;
        n = s;
        if (en && b.max_value > b.min_value) begin
            if (s.value == b.min_value)
                n.up = 1'b1;
            else if (s.value == b.max_value)
                n.up = 1'b0;
            if (n.up && s.value < b.max_value)
                n.value = s.value + 4'd1;
            else if (!n.up && s.value > b.min_value)
                n.value = s.value - 4'd1;
        end
        return n;
    endfunction

    task automatic check_state(counter_state_t got, counter_state_t exp, string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s: state value %0d up %0b, expected value %0d up %0b",
                     $time, msg, got.value, got.up, exp.value, exp.up);
        end
    endtask

    task automatic check_display(anode_t got_an, seg_t got_seg, anode_t exp_an,
                                 seg_t exp_seg, string msg);
        checks++;
        if (got_an !== exp_an || got_seg !== exp_seg) begin
            errors++;
            $display("FAIL %0t: %s: an %b seg %b, expected an %b seg %b",
                     $time, msg, got_an, got_seg, exp_an, exp_seg);
        end
    endtask

    // Counter state settles on the edge after each count tick
    task automatic wait_count_update();
        do @(negedge clk); while (!(cyc > 1 && cyc % COUNT_DIV == 1));
    endtask

    task automatic report_test(string name, int start_errors);
        tests_run++;
        if (errors > start_errors) begin
            tests_failed++;
            $display("Test %s finished with %0d errors", name, errors - start_errors);
        end else begin
            $display("Test %s passed", name);
        end
    endtask

    task automatic test_reset();
        int start_errors;
        start_errors = errors;
        @(negedge clk);
        model.value = 4'd3;
        model.up    = 1'b1;
        check_state(state, model, "reset state");
        check_display(an, seg, 4'b1111, SEG_BLANK, "reset display");
        report_test("reset", start_errors);
    endtask

    task automatic test_bounce();
        int start_errors;
        start_errors = errors;
        wait_count_update();
        @(posedge clk);
        bounds.min_value <= 4'($unsigned($random(seed)) % 4);       // Keeps 3 in range
        bounds.max_value <= 4'(4 + $unsigned($random(seed)) % 12);
        enable <= 1'b1;
        repeat (30) begin
            wait_count_update();
            model = model_step(model, bounds, enable);
            check_state(state, model, "bounce");
        end
        report_test("bounce", start_errors);
    endtask

    task automatic test_hold();
        int start_errors;
        start_errors = errors;
        @(posedge clk);
        enable <= 1'b0;
        repeat (3) begin
            wait_count_update();
            check_state(state, model, "hold with enable low");
        end
        @(posedge clk);
        enable           <= 1'b1;
        bounds.min_value <= 4'd9;
        bounds.max_value <= 4'd4;
        repeat (3) begin
            wait_count_update();
            check_state(state, model, "hold with empty range");
        end
        report_test("hold", start_errors);
    endtask

    task automatic test_flip();
        int             start_errors;
        int             flips;
        counter_state_t flipped;
        start_errors = errors;
        flips = 0;
        @(posedge clk);
        bounds.min_value <= 4'd0;
        bounds.max_value <= 4'd15;
        flip_btn         <= 1'b1;
        for (int t = 0; t < 5; t++) begin
            wait_count_update();
            flipped.value = model.value;
            flipped.up    = ~model.up;
            if (flips == 0 && state === flipped) begin
                model = flipped;    // Flip step holds the value
                flips++;
            end else begin
                model = model_step(model, bounds, enable);
            end
            check_state(state, model, "flip press");
            if (t == 1) begin
                @(posedge clk) flip_btn <= 1'b0;    // Held 8 refresh periods
            end
        end
        if (flips != 1) begin
            errors++;
            $display("Flip press changed direction %0d times instead of once", flips);
        end
        // One refresh sample only, must be ignored
        @(posedge clk) flip_btn <= 1'b1;
        @(posedge clk);
        @(posedge clk) flip_btn <= 1'b0;
        repeat (3) begin
            wait_count_update();
            model = model_step(model, bounds, enable);
            check_state(state, model, "flip glitch");
        end
        report_test("flip", start_errors);
    endtask

    task automatic test_clear();
        int start_errors;
        start_errors = errors;
        @(posedge clk);
        bounds.min_value <= 4'd12;
        bounds.max_value <= 4'd13;
        clear_btn        <= 1'b1;
        model.value = 4'd12;
        model.up    = 1'b1;
        // Must land before the next count tick
        for (int i = 0; i < COUNT_DIV - 1 && state !== model; i++) begin
            @(negedge clk);
        end
        check_state(state, model, "clear before count tick");
        @(posedge clk) clear_btn <= 1'b0;
        repeat (2) begin
            wait_count_update();
            model = model_step(model, bounds, enable);
            check_state(state, model, "count after clear");
        end
        @(posedge clk) enable <= 1'b0;      // Park at 12 counting down
        report_test("clear", start_errors);
    endtask

    task automatic test_display();
        int     start_errors;
        anode_t exp_an;
        seg_t   exp_seg[4];
        start_errors = errors;
        exp_seg[0] = SEG_DOWN;
        exp_seg[1] = SEG_DOWN;
        exp_seg[2] = seg_of_digit(4'd2);
        exp_seg[3] = seg_of_digit(4'd1);
        do @(negedge clk); while (cyc % 8 != 3);    // Scanner just selected digit 0
        for (int d = 0; d < 4; d++) begin
            if (d > 0) begin
                repeat (REFRESH_DIV) @(negedge clk);
            end
            exp_an    = 4'b1111;
            exp_an[d] = 1'b0;
            check_display(an, seg, exp_an, exp_seg[d], $sformatf("digit %0d", d));
        end
        report_test("display", start_errors);
    endtask

    initial begin
        seed             = 69502;
        clk              = 1'b0;
        rst_n            = 1'b0;
        enable           = 1'b0;
        flip_btn         = 1'b0;
        clear_btn        = 1'b0;
        bounds.min_value = 4'd3;
        bounds.max_value = 4'd7;
        cyc              = 0;
        run_cycles       = 0;
        errors           = 0;
        checks           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_bounce();
        test_hold();
        test_flip();
        test_clear();
        test_display();
        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
src/pingpong_pkg.sv
src/tick_gen.sv
src/button_conditioner.sv
src/ping_pong_counter.sv
src/digit_scanner.sv
src/pingpong_top.sv
verif/tb_pingpong.sv

//--- Bender.yml
package:
  name: pingpong

sources:
  # Package first, then leaf modules, then the top level
  - src/pingpong_pkg.sv
  - src/tick_gen.sv
  - src/button_conditioner.sv
  - src/ping_pong_counter.sv
  - src/digit_scanner.sv
  - src/pingpong_top.sv

  - target: test
    files:
      - verif/tb_pingpong.sv

export_include_dirs: []

dependencies: {}

frozen: false
